/* flist.f */
rtl/cf_pkg.sv
rtl/branch_comparator.sv
rtl/instr_decoder.sv
rtl/branch_unit.sv
rtl/control_flow_top.sv
sim/tb_control_flow.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
# Exits with status 1 when the log reports a failure.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f flist.f \
    --top-module tb_control_flow \
    -Mdir obj_dir \
    -o tb_control_flow

./obj_dir/tb_control_flow > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

exit 0

/* sim/tb_control_flow.sv */
// Random and directed test of the control-flow path against a reference model
// Expected results are queued at each rising edge and compared at the falling edge
// The model takes the encoded immediates and does not decode instruction words

module tb_control_flow;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          N_RANDOM   = 560;
    localparam int          N_CYCLES   = 600;
    localparam int          TIMEOUT_NS = N_CYCLES * 20 + 5 * 20 + 500;
    localparam logic [31:0] LFSR_SEED  = 32'd47;
    localparam logic [31:0] LFSR_TAPS  = 32'hD000_0001;

    // Instruction classes picked by the stimulus
    localparam int K_BRANCH = 0;
    localparam int K_JAL    = 1;
    localparam int K_JALR   = 2;
    localparam int K_ECALL  = 3;
    localparam int K_EBREAK = 4;
    localparam int K_MRET   = 5;
    localparam int K_OTHER  = 6;

    logic                clk;
    logic                reset;
    logic                enable;
    logic                irq;
    cf_pkg::instr_word_t instr;
    cf_pkg::word_t       pc;
    cf_pkg::word_t       xs1;
    cf_pkg::word_t       xs2;
    cf_pkg::word_t       pc_next;
    logic                pc_valid;

    int              cur_kind;   // Class of the item on the inputs
    cf_pkg::word_t   cur_imm;    // Sign-extended immediate that was encoded
    cf_pkg::funct3_t cur_f3;
    logic [31:0]     lfsr;
    logic            model_exc;
    cf_pkg::word_t   model_mepc;
    logic            exp_valid_q[$];
    cf_pkg::word_t   exp_pc_q[$];
    int              checks;
    int              errors;

    control_flow_top dut (
        .clk     (clk),
        .reset   (reset),
        .enable  (enable),
        .irq     (irq),
        .instr   (instr),
        .pc      (pc),
        .xs1     (xs1),
        .xs2     (xs2),
        .pc_next (pc_next),
        .pc_valid(pc_valid)
    );

    always #10 clk = ~clk;

    // One Galois LFSR step per bit with the newest bit in the LSB
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            fb   = lfsr[0];
            lfsr = {1'b0, lfsr[31:1]} ^ (fb ? LFSR_TAPS : 32'h0);
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic branch_holds(input cf_pkg::funct3_t f3,
                                          input cf_pkg::word_t a,
                                          input cf_pkg::word_t b);
        case (f3)
            cf_pkg::F3_BEQ:  return a == b;
            cf_pkg::F3_BNE:  return a != b;
            cf_pkg::F3_BLT:  return $signed(a) < $signed(b);
            cf_pkg::F3_BGE:  return $signed(a) >= $signed(b);
            cf_pkg::F3_BLTU: return a < b;
            cf_pkg::F3_BGEU: return a >= b;
            default:         return 1'b0;
        endcase
    endfunction

    function automatic cf_pkg::word_t align_word(input cf_pkg::word_t a);
        return {a[31:2], 2'b00};
    endfunction

    // Resolve rule for one accepted item that also updates the model state
    function automatic cf_pkg::word_t predict_next(input int kind, input cf_pkg::word_t imm,
                                                   input cf_pkg::funct3_t f3,
                                                   input cf_pkg::word_t pc_in,
                                                   input cf_pkg::word_t a,
                                                   input cf_pkg::word_t b,
                                                   input logic irq_in);
        cf_pkg::word_t target;
        cf_pkg::word_t nxt;
        logic          accept;
        logic          trap;
        case (kind)
            K_MRET:   target = model_mepc;
            K_JAL:    target = align_word(pc_in + imm);
            K_JALR:   target = align_word(a + imm);
            K_BRANCH: target = branch_holds(f3, a, b) ? align_word(pc_in + imm) : pc_in + 32'd4;
            default:  target = pc_in + 32'd4;
        endcase
        accept = irq_in && !model_exc;
        trap   = (kind == K_ECALL) || (kind == K_EBREAK);
        if (accept) begin
            nxt = cf_pkg::IRQ_ADDRESS;
        end else if (trap) begin
            nxt = cf_pkg::TRAP_ADDRESS;
        end else begin
            nxt = target;
        end
        if (accept || trap) begin
            model_mepc = target;
        end
        if (kind == K_MRET) begin
            model_exc = 1'b0;
        end else if (irq_in) begin
            model_exc = 1'b1;
        end
        return nxt;
    endfunction

    function automatic int pick_kind();
        logic [31:0] r;
        r = rand_bits(4);
        case (r[3:0])
            4'd6, 4'd15:  return K_JALR;
            4'd7:         return K_JAL;
            4'd8, 4'd9:   return K_OTHER;
            4'd14:        return K_OTHER;
            4'd10:        return K_ECALL;
            4'd11:        return K_EBREAK;
            4'd12, 4'd13: return K_MRET;
            default:      return K_BRANCH;
        endcase
    endfunction

    // Builds a real RV32I word for the class and drives it for one cycle
    task automatic issue_instr(input int kind, input logic irq_in);
        logic [31:0]         r;
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [6:0]          op;
        cf_pkg::funct3_t     f3;
        cf_pkg::word_t       imm;
        cf_pkg::word_t       a;
        cf_pkg::word_t       b;
        cf_pkg::word_t       pc_val;
        cf_pkg::instr_word_t word;
        r   = rand_bits(15);
        rd  = r[4:0];
        rs1 = r[9:5];
        rs2 = r[14:10];
        a   = rand_bits(32);
        r   = rand_bits(2);
        b   = rand_bits(32);
        if (r[1:0] == 2'd0) begin
            b = a;             // Equal operands
        end else if (r[1:0] == 2'd1) begin
            b[31] = ~a[31];    // Sign bits differ
        end
        r      = rand_bits(30);
        pc_val = {r[29:0], 2'b00};
        imm    = '0;
        f3     = '0;
        case (kind)
            K_BRANCH: begin
                r    = rand_bits(12);
                imm  = {{19{r[11]}}, r[11:0], 1'b0};
                r    = rand_bits(3);
                f3   = r[2:0];  // All eight codes including the undefined 2 and 3
                word = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], cf_pkg::OPC_BRANCH};
            end
            K_JAL: begin
                r    = rand_bits(20);
                imm  = {{11{r[19]}}, r[19:0], 1'b0};
                word = {imm[20], imm[10:1], imm[11], imm[19:12], rd, cf_pkg::OPC_JAL};
            end
            K_JALR: begin
                r    = rand_bits(12);
                imm  = {{20{r[11]}}, r[11:0]};
                word = {imm[11:0], rs1, 3'b000, rd, cf_pkg::OPC_JALR};
            end
            K_ECALL:  word = {cf_pkg::FN12_ECALL, 13'd0, cf_pkg::OPC_SYSTEM};
            K_EBREAK: word = {cf_pkg::FN12_EBREAK, 13'd0, cf_pkg::OPC_SYSTEM};
            K_MRET:   word = {cf_pkg::FN12_MRET, 13'd0, cf_pkg::OPC_SYSTEM};
            default: begin
                r = rand_bits(2);
                if (r[1:0] == 2'd0) begin
                    r  = rand_bits(32);
                    f3 = r[14:12];
                    if (f3 == 3'b000) begin
                        f3 = 3'b010;  // CSR access rather than a trap
                    end
                    word = {r[31:15], f3, r[11:7], cf_pkg::OPC_SYSTEM};
                end else if (r[1:0] == 2'd1) begin
                    word = {12'h105, 13'd0, cf_pkg::OPC_SYSTEM};  // wfi
                end else begin
                    r  = rand_bits(32);
                    op = {r[6:2], 2'b11};
                    if (op == cf_pkg::OPC_JAL || op == cf_pkg::OPC_JALR ||
                        op == cf_pkg::OPC_BRANCH || op == cf_pkg::OPC_SYSTEM) begin
                        op = 7'b0110011;
                    end
                    word = {r[31:7], op};
                end
            end
        endcase
        enable   = 1'b1;
        irq      = irq_in;
        instr    = word;
        pc       = pc_val;
        xs1      = a;
        xs2      = b;
        cur_kind = kind;
        cur_imm  = imm;
        cur_f3   = f3;
        @(negedge clk);
    endtask

    // Enable low with a trap or mret word and random irq leaves the state as it is
    task automatic idle_cycle();
        logic [31:0] r;
        r      = rand_bits(2);
        enable = 1'b0;
        irq    = r[0];
        instr  = r[1] ? {cf_pkg::FN12_ECALL, 13'd0, cf_pkg::OPC_SYSTEM}
                      : {cf_pkg::FN12_MRET, 13'd0, cf_pkg::OPC_SYSTEM};
        pc     = rand_bits(32);
        xs1    = rand_bits(32);
        xs2    = rand_bits(32);
        cur_kind = K_OTHER;
        @(negedge clk);
    endtask

    always @(posedge clk) begin
        if (reset) begin
            model_exc  = 1'b0;
            model_mepc = '0;
            exp_valid_q.push_back(1'b0);
        end else if (enable) begin
            exp_valid_q.push_back(1'b1);
            exp_pc_q.push_back(predict_next(cur_kind, cur_imm, cur_f3, pc, xs1, xs2, irq));
        end else begin
            exp_valid_q.push_back(1'b0);
        end
    end

    // Outputs are stable mid-cycle
    always @(negedge clk) begin : compare
        logic          want_valid;
        cf_pkg::word_t want_pc;
        if (exp_valid_q.size() > 0) begin
            want_valid = exp_valid_q.pop_front();
            checks++;
            if (pc_valid !== want_valid) begin
                errors++;
                $display("Error at %0t ns: pc_valid expected %b, got %b",
                         $time, want_valid, pc_valid);
            end
            if (want_valid) begin
                want_pc = exp_pc_q.pop_front();
                checks++;
                if (pc_next !== want_pc) begin
                    errors++;
                    $display("Error at %0t ns: pc_next expected %h, got %h",
                             $time, want_pc, pc_next);
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Simulation did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] r;
        int          k;
        clk      = 1'b0;
        reset    = 1'b1;
        enable   = 1'b0;
        irq      = 1'b0;
        instr    = '0;
        pc       = '0;
        xs1      = '0;
        xs2      = '0;
        cur_kind = K_OTHER;
        cur_imm  = '0;
        cur_f3   = '0;
        lfsr     = LFSR_SEED;
        checks   = 0;
        errors   = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        idle_cycle();
        // Trap entry and return
        issue_instr(K_ECALL, 1'b0);
        issue_instr(K_BRANCH, 1'b0);
        issue_instr(K_MRET, 1'b0);
        issue_instr(K_EBREAK, 1'b0);
        idle_cycle();
        issue_instr(K_MRET, 1'b0);
        // Interrupt entry, masked irq, then mret together with irq
        issue_instr(K_JAL, 1'b1);
        issue_instr(K_BRANCH, 1'b1);
        issue_instr(K_JALR, 1'b0);
        issue_instr(K_MRET, 1'b0);
        issue_instr(K_MRET, 1'b1);
        issue_instr(K_BRANCH, 1'b1);
        issue_instr(K_MRET, 1'b0);
        repeat (N_RANDOM) begin
            r = rand_bits(3);
            if (r[2:0] == 3'd0) begin
                idle_cycle();
            end else begin
                k = pick_kind();
                r = rand_bits(4);
                issue_instr(k, r[3:0] == 4'd0);  // irq about one cycle in sixteen
            end
        end
        enable = 1'b0;
        irq    = 1'b0;
        repeat (3) @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* rtl/control_flow_top.sv */
// Two-stage control-flow path, pc_next one clock after the inputs
// No back-pressure; enable low just yields pc_valid low a cycle later

module control_flow_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    input  logic                irq,
    input  cf_pkg::instr_word_t instr,
    input  cf_pkg::word_t       pc,
    input  cf_pkg::word_t       xs1,
    input  cf_pkg::word_t       xs2,
    output cf_pkg::word_t       pc_next,
    output logic                pc_valid
);

    logic            d_valid;
    logic            d_irq;
    logic            d_is_jump;
    logic            d_is_branch;
    logic            d_is_mret;
    logic            d_is_trap;
    cf_pkg::funct3_t d_funct3;
    cf_pkg::word_t   d_xs1;
    cf_pkg::word_t   d_xs2;
    cf_pkg::word_t   d_address;
    cf_pkg::word_t   d_pc_incr;

    instr_decoder decode (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .irq        (irq),
        .instr      (instr),
        .pc         (pc),
        .xs1        (xs1),
        .xs2        (xs2),
        .d_valid    (d_valid),
        .d_irq      (d_irq),
        .d_is_jump  (d_is_jump),
        .d_is_branch(d_is_branch),
        .d_is_mret  (d_is_mret),
        .d_is_trap  (d_is_trap),
        .d_funct3   (d_funct3),
        .d_xs1      (d_xs1),
        .d_xs2      (d_xs2),
        .d_address  (d_address),
        .d_pc_incr  (d_pc_incr)
    );

    branch_unit resolve (
        .clk      (clk),
        .reset    (reset),
        .valid    (d_valid),
        .irq      (d_irq),
        .is_jump  (d_is_jump),
        .is_branch(d_is_branch),
        .is_mret  (d_is_mret),
        .is_trap  (d_is_trap),
        .funct3   (d_funct3),
        .xs1      (d_xs1),
        .xs2      (d_xs2),
        .address  (d_address),
        .pc_incr  (d_pc_incr),
        .pc_next  (pc_next)
    );

    assign pc_valid = d_valid;  // Resolve stage is combinational

endmodule

/* rtl/branch_unit.sv */
// Resolve stage, pc_next is combinational from the decode registers
// Exception state and mepc only change on cycles with valid high
// A single exception level, no nesting of interrupts

module branch_unit (
    input  logic            clk,
    input  logic            reset,
    input  logic            valid,
    input  logic            irq,
    input  logic            is_jump,
    input  logic            is_branch,
    input  logic            is_mret,
    input  logic            is_trap,
    input  cf_pkg::funct3_t funct3,
    input  cf_pkg::word_t   xs1,
    input  cf_pkg::word_t   xs2,
    input  cf_pkg::word_t   address,
    input  cf_pkg::word_t   pc_incr,
    output cf_pkg::word_t   pc_next
);

    logic          taken;
    cf_pkg::word_t pc_target;     // Normal-flow target
    logic          except_state;  // Inside a handler
    logic          accept_irq;
    cf_pkg::word_t mepc;

    branch_comparator cmp (
        .funct3(funct3),
        .a     (xs1),
        .b     (xs2),
        .taken (taken)
    );

    always_comb begin
        if (is_mret) begin
            pc_target = mepc;
        end else if (is_jump || (is_branch && taken)) begin
            pc_target = address;
        end else begin
            pc_target = pc_incr;
        end
    end

    assign accept_irq = irq && !except_state;  // Masked while in a handler

    always_comb begin
        if (accept_irq) begin
            pc_next = cf_pkg::IRQ_ADDRESS;
        end else if (is_trap) begin
            pc_next = cf_pkg::TRAP_ADDRESS;
        end else begin
            pc_next = pc_target;
        end
    end

    // mret wins over a new irq in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            except_state <= 1'b0;
        end else if (valid) begin
            if (is_mret) begin
                except_state <= 1'b0;
            end else if (irq) begin
                except_state <= 1'b1;
            end
        end
    end

    // Return address is the target the interrupted instruction would have taken
    always_ff @(posedge clk) begin
        if (reset) begin
            mepc <= '0;
        end else if (valid && (accept_irq || is_trap)) begin
            mepc <= pc_target;
        end
    end

endmodule

/* rtl/instr_decoder.sv */
// Decode stage, one instruction per cycle, no stall
// Only d_valid is reset; payload outputs follow the inputs every cycle
// Illegal encodings are not flagged and decode as sequential flow

module instr_decoder (
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    input  logic                irq,
    input  cf_pkg::instr_word_t instr,
    input  cf_pkg::word_t       pc,
    input  cf_pkg::word_t       xs1,
    input  cf_pkg::word_t       xs2,
    output logic                d_valid,
    output logic                d_irq,
    output logic                d_is_jump,
    output logic                d_is_branch,
    output logic                d_is_mret,
    output logic                d_is_trap,
    output cf_pkg::funct3_t     d_funct3,
    output cf_pkg::word_t       d_xs1,
    output cf_pkg::word_t       d_xs2,
    output cf_pkg::word_t       d_address,
    output cf_pkg::word_t       d_pc_incr
);

    logic [6:0]      opcode;
    cf_pkg::funct3_t funct3;
    logic [11:0]     funct12;
    cf_pkg::word_t   imm_i;
    cf_pkg::word_t   imm_b;
    cf_pkg::word_t   imm_j;
    cf_pkg::word_t   target;
    logic            is_system;
    logic            is_jump;
    logic            is_branch;
    logic            is_mret;
    logic            is_trap;

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign funct12 = instr[31:20];

    // Sign-extended immediates
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign is_system = (opcode == cf_pkg::OPC_SYSTEM) && (funct3 == 3'b000);
    assign is_jump   = (opcode == cf_pkg::OPC_JAL) || (opcode == cf_pkg::OPC_JALR);
    assign is_branch = (opcode == cf_pkg::OPC_BRANCH);
    assign is_mret   = is_system && (funct12 == cf_pkg::FN12_MRET);
    assign is_trap   = is_system && ((funct12 == cf_pkg::FN12_ECALL) ||
                                     (funct12 == cf_pkg::FN12_EBREAK));

    always_comb begin
        case (opcode)
            cf_pkg::OPC_JAL:    target = pc + imm_j;
            cf_pkg::OPC_JALR:   target = xs1 + imm_i;  // May be odd, aligned below
            cf_pkg::OPC_BRANCH: target = pc + imm_b;
            default:            target = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            d_valid <= 1'b0;
        end else begin
            d_valid <= enable;
        end
    end

    // Stage payload
    always_ff @(posedge clk) begin
        d_irq       <= irq;
        d_is_jump   <= is_jump;
        d_is_branch <= is_branch;
        d_is_mret   <= is_mret;
        d_is_trap   <= is_trap;
        d_funct3    <= funct3;
        d_xs1       <= xs1;
        d_xs2       <= xs2;
        d_address   <= {target[31:2], 2'b00};
        d_pc_incr   <= pc + 32'd4;
    end

endmodule

/* rtl/branch_comparator.sv */
// Operand compare for the six RV32I branch conditions
// Unused condition codes never take the branch

module branch_comparator (
    input  cf_pkg::funct3_t funct3,
    input  cf_pkg::word_t   a,
    input  cf_pkg::word_t   b,
    output logic            taken
);

    logic equal;
    logic less_signed;
    logic less_unsigned;

    assign equal         = (a == b);
    assign less_signed   = ($signed(a) < $signed(b));
    assign less_unsigned = (a < b);

    always_comb begin
        case (funct3)
            cf_pkg::F3_BEQ:  taken = equal;
            cf_pkg::F3_BNE:  taken = !equal;
            cf_pkg::F3_BLT:  taken = less_signed;
            cf_pkg::F3_BGE:  taken = !less_signed;
            cf_pkg::F3_BLTU: taken = less_unsigned;
            cf_pkg::F3_BGEU: taken = !less_unsigned;
            default:         taken = 1'b0;
        endcase
    end

endmodule

/* rtl/cf_pkg.sv */
// Shared types and constants for the RV32I control-flow path
// Interrupt and trap entry addresses are fixed here for the whole design

package cf_pkg;

    typedef logic [31:0] word_t;        // Address or data word
    typedef logic [31:0] instr_word_t;  // Raw instruction as fetched
    typedef logic [2:0]  funct3_t;      // Branch condition field

    // Major opcodes that change control flow
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // Branch conditions, codes 2 and 3 are unused
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // SYSTEM instructions with funct3 == 0, selected by bits 31:20
    localparam logic [11:0] FN12_ECALL  = 12'h000;
    localparam logic [11:0] FN12_EBREAK = 12'h001;
    localparam logic [11:0] FN12_MRET   = 12'h302;

    // Entry points of the handlers
    localparam word_t IRQ_ADDRESS  = 32'h0000_0010;
    localparam word_t TRAP_ADDRESS = 32'h0000_0020;

endpackage
